// ==== source/rnPkg.sv ====
package rnPkg;

	// datapath and rename sizing
	localparam int XLEN = 32;
	localparam int RP = 4;
	localparam int RB = 2;
	localparam int NREG = 32;
	localparam int REGW = 5;

	// in-flight limits
	localparam int ROB_DEPTH = 8;
	localparam int TAGW = $clog2(ROB_DEPTH);
	localparam int INQ_DEPTH = 4;
	// width of the sink credit counter
	localparam int OUT_CREDITS_MAX = 4;

	// major opcodes
	localparam logic [6:0] OP_R = 7'b0110011;
	localparam logic [6:0] OP_I = 7'b0010011;

	// operation code is {funct7[5], funct3}
	localparam int FUNC_W = 4;
	localparam logic [FUNC_W-1:0] F_ADD = 4'b0000;
	localparam logic [FUNC_W-1:0] F_SUB = 4'b1000;
	localparam logic [FUNC_W-1:0] F_XOR = 4'b0100;

	// one instruction word, two readings
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
	} instrWord_u;

endpackage

// ==== source/phyRegister.sv ====
`timescale 1ns/10ps

module phyRegister #(
	parameter int XLEN = rnPkg::XLEN,
	parameter int RP = rnPkg::RP,
	parameter int RB = rnPkg::RB
) (
	input  logic CLK,
	input  logic arstN,

	input  logic renameValid,
	input  logic [rnPkg::REGW-1:0] renameReg,
	input  logic [RB-1:0] renameCopy,
	output logic [rnPkg::NREG-1:0][RB-1:0] renamePtr,
	output logic [rnPkg::NREG-1:0][RP-1:0] inUse,

	input  logic wbValid,
	input  logic [rnPkg::REGW-1:0] wbReg,
	input  logic [RB-1:0] wbCopy,
	input  logic [XLEN-1:0] wbData,
	output logic [rnPkg::NREG-1:0][RP-1:0] writtenBack,

	input  logic [rnPkg::REGW-1:0] rdReg1,
	input  logic [RB-1:0] rdCopy1,
	output logic [XLEN-1:0] rdData1,
	input  logic [rnPkg::REGW-1:0] rdReg2,
	input  logic [RB-1:0] rdCopy2,
	output logic [XLEN-1:0] rdData2,

	input  logic commitValid,
	input  logic [rnPkg::REGW-1:0] commitReg,
	input  logic [RB-1:0] commitNewCopy,
	input  logic [RB-1:0] commitOldCopy
);
	import rnPkg::*;

	// copy zero is the live one out of reset
	localparam logic [RP-1:0] COPY0 = 1;

	// committed copy of each register
	logic [NREG-1:0][RB-1:0] archPtr;
	logic [XLEN-1:0] regData [NREG][RP];

	// x0 entries are reset once and never touched again
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			archPtr <= '0;
			renamePtr <= '0;
			inUse <= {NREG{COPY0}};
			writtenBack <= {NREG{COPY0}};
		end else begin
			// new producer claims a free copy
			if (renameValid && renameReg != '0) begin
				renamePtr[renameReg] <= renameCopy;
				inUse[renameReg][renameCopy] <= 1'b1;
			end
			// result landed, readers may go
			if (wbValid && wbReg != '0) begin
				writtenBack[wbReg][wbCopy] <= 1'b1;
			end
			// new copy becomes architectural, old one back to the pool
			if (commitValid && commitReg != '0) begin
				archPtr[commitReg] <= commitNewCopy;
				inUse[commitReg][commitOldCopy] <= 1'b0;
				writtenBack[commitReg][commitOldCopy] <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wbValid && wbReg != '0) begin
			regData[wbReg][wbCopy] <= wbData;
		end
	end

	// x0 always reads zero
	assign rdData1 = (rdReg1 == '0) ? '0 : regData[rdReg1][rdCopy1];
	assign rdData2 = (rdReg2 == '0) ? '0 : regData[rdReg2][rdCopy2];

	// a fresh copy must come from the free pool
	renameFree: assert property (@(posedge CLK) disable iff (!arstN)
		renameValid && renameReg != '0 |-> !inUse[renameReg][renameCopy]);

	// writeback hits a claimed copy that was still pending
	wbPending: assert property (@(posedge CLK) disable iff (!arstN)
		wbValid && wbReg != '0 |->
			inUse[wbReg][wbCopy] && !writtenBack[wbReg][wbCopy]);

	// the freed copy is the old architectural one, never the incoming one
	commitFree: assert property (@(posedge CLK) disable iff (!arstN)
		commitValid && commitReg != '0 |->
			commitOldCopy != commitNewCopy
			&& archPtr[commitReg] == commitOldCopy
			&& writtenBack[commitReg][commitNewCopy]);

endmodule

// ==== source/renameStage.sv ====
`timescale 1ns/10ps

module renameStage #(
	parameter int RP = rnPkg::RP,
	parameter int RB = rnPkg::RB,
	parameter int XLEN = rnPkg::XLEN
) (
	input  logic CLK,
	input  logic arstN,
	input  logic inValid,
	input  rnPkg::instrWord_u inInstr,
	output logic inCredit,
	input  logic [rnPkg::NREG-1:0][RB-1:0] renamePtr,
	input  logic [rnPkg::NREG-1:0][RP-1:0] inUse,
	output logic renameValid,
	output logic [rnPkg::REGW-1:0] renameReg,
	output logic [RB-1:0] renameCopy,
	output logic issueValid,
	output logic [rnPkg::FUNC_W-1:0] issueOp,
	output logic [rnPkg::REGW-1:0] issueRd,
	output logic [RB-1:0] issueRdCopy,
	output logic [rnPkg::REGW-1:0] issueRs1,
	output logic [RB-1:0] issueRs1Copy,
	output logic [rnPkg::REGW-1:0] issueRs2,
	output logic [RB-1:0] issueRs2Copy,
	output logic [XLEN-1:0] issueImm,
	output logic issueUseImm,
	output logic [rnPkg::TAGW-1:0] issueTag,
	input  logic issueReady,
	input  logic robFull,
	output logic robAlloc,
	output logic [rnPkg::REGW-1:0] robRd,
	output logic [RB-1:0] robNewCopy,
	output logic [RB-1:0] robOldCopy,
	input  logic [rnPkg::TAGW-1:0] tailTag
);
	import rnPkg::*;

	localparam int QW = $clog2(INQ_DEPTH);

	instrWord_u qMem [INQ_DEPTH];
	logic [QW-1:0] qWr;
	logic [QW-1:0] qRd;
	logic [QW:0] qCount;
	instrWord_u head;
	logic isImm;
	logic [REGW-1:0] hRd;
	logic [REGW-1:0] hRs1;
	logic [REGW-1:0] hRs2;
	logic [FUNC_W-1:0] hOp;
	logic freeFound;
	logic [RB-1:0] freeCopy;
	logic fire;

	// decode the queue head
	assign head = qMem[qRd];
	assign isImm = head.i.opcode == OP_I;
	assign hRd = head.r.rd;
	assign hRs1 = head.r.rs1;
	// I-form has no rs2, x0 stands in
	assign hRs2 = (head.r.opcode == OP_R) ? head.r.rs2 : '0;
	assign hOp = isImm ? {1'b0, head.i.funct3} : {head.r.funct7[5], head.r.funct3};

	// lowest free copy of rd
	always_comb begin
		freeFound = 1'b0;
		freeCopy = '0;
		for (int c = RP - 1; c >= 0; c--) begin
			if (!inUse[hRd][c]) begin
				freeFound = 1'b1;
				freeCopy = RB'(c);
			end
		end
	end

	assign fire = (qCount != '0) && (hRd == '0 || freeFound) && !robFull && issueReady;
	assign inCredit = fire;

	assign renameValid = fire && hRd != '0;
	assign renameReg = hRd;
	assign renameCopy = freeCopy;

	assign robAlloc = fire;
	assign robRd = hRd;
	assign robNewCopy = (hRd == '0) ? '0 : freeCopy;
	assign robOldCopy = renamePtr[hRd];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			qWr <= '0;
			qRd <= '0;
			qCount <= '0;
			issueValid <= 1'b0;
		end else begin
			qWr <= qWr + QW'(inValid);
			qRd <= qRd + QW'(fire);
			qCount <= qCount + (QW+1)'(inValid) - (QW+1)'(fire);
			issueValid <= fire;
		end
	end

	always_ff @(posedge CLK) begin
		if (inValid) begin
			qMem[qWr] <= inInstr;
		end
		// sources see the pointers before this rename lands
		if (fire) begin
			issueOp <= hOp;
			issueRd <= hRd;
			issueRdCopy <= robNewCopy;
			issueRs1 <= hRs1;
			issueRs1Copy <= renamePtr[hRs1];
			issueRs2 <= hRs2;
			issueRs2Copy <= renamePtr[hRs2];
			issueImm <= {{(XLEN-12){head.i.imm[11]}}, head.i.imm};
			issueUseImm <= isImm;
			issueTag <= tailTag;
		end
	end

	// sender spends a credit per word, so a full queue must be draining
	queueOverrun: assert property (@(posedge CLK) disable iff (!arstN)
		inValid |-> qCount != (QW+1)'(INQ_DEPTH) || fire);

endmodule

// ==== source/execStage.sv ====
`timescale 1ns/10ps

module execStage #(
	parameter int XLEN = rnPkg::XLEN,
	parameter int RB = rnPkg::RB
) (
	input  logic CLK,
	input  logic arstN,
	input  logic issueValid,
	input  logic [rnPkg::FUNC_W-1:0] issueOp,
	input  logic [rnPkg::REGW-1:0] issueRd,
	input  logic [RB-1:0] issueRdCopy,
	input  logic [rnPkg::REGW-1:0] issueRs1,
	input  logic [RB-1:0] issueRs1Copy,
	input  logic [rnPkg::REGW-1:0] issueRs2,
	input  logic [RB-1:0] issueRs2Copy,
	input  logic [XLEN-1:0] issueImm,
	input  logic issueUseImm,
	input  logic [rnPkg::TAGW-1:0] issueTag,
	output logic issueReady,
	input  logic [rnPkg::NREG-1:0][(2**RB)-1:0] writtenBack,
	output logic [rnPkg::REGW-1:0] rdReg1,
	output logic [RB-1:0] rdCopy1,
	input  logic [XLEN-1:0] rdData1,
	output logic [rnPkg::REGW-1:0] rdReg2,
	output logic [RB-1:0] rdCopy2,
	input  logic [XLEN-1:0] rdData2,
	output logic wbValid,
	output logic [rnPkg::REGW-1:0] wbReg,
	output logic [RB-1:0] wbCopy,
	output logic [XLEN-1:0] wbData,
	output logic [rnPkg::TAGW-1:0] wbTag
);
	import rnPkg::*;

	logic slotValid;
	logic [FUNC_W-1:0] slotOp;
	logic [XLEN-1:0] slotImm;
	logic slotUseImm;
	logic srcReady;
	logic [XLEN-1:0] opB;

	// I-form carries x0 as rs2, which is always written back
	assign srcReady = writtenBack[rdReg1][rdCopy1] && writtenBack[rdReg2][rdCopy2];
	assign wbValid = slotValid && srcReady;
	// an issue already on its way fills the slot at the next edge
	assign issueReady = (!slotValid || wbValid) && !issueValid;

	assign opB = slotUseImm ? slotImm : rdData2;

	always_comb begin
		case (slotOp)
			F_ADD: wbData = rdData1 + opB;
			F_SUB: wbData = rdData1 - opB;
			F_XOR: wbData = rdData1 ^ opB;
			default: wbData = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			slotValid <= 1'b0;
		end else if (issueValid) begin
			slotValid <= 1'b1;
		end else if (wbValid) begin
			slotValid <= 1'b0;
		end
	end

	// slot payload, source fields double as read addresses
	always_ff @(posedge CLK) begin
		if (issueValid) begin
			slotOp <= issueOp;
			slotImm <= issueImm;
			slotUseImm <= issueUseImm;
			rdReg1 <= issueRs1;
			rdCopy1 <= issueRs1Copy;
			rdReg2 <= issueRs2;
			rdCopy2 <= issueRs2Copy;
			wbReg <= issueRd;
			wbCopy <= issueRdCopy;
			wbTag <= issueTag;
		end
	end

endmodule

// ==== source/commitStage.sv ====
`timescale 1ns/10ps

module commitStage #(
	parameter int RB = rnPkg::RB,
	parameter int ROB_DEPTH = rnPkg::ROB_DEPTH
) (
	input  logic CLK,
	input  logic arstN,
	input  logic robAlloc,
	input  logic [rnPkg::REGW-1:0] robRd,
	input  logic [RB-1:0] robNewCopy,
	input  logic [RB-1:0] robOldCopy,
	output logic robFull,
	output logic [$clog2(ROB_DEPTH)-1:0] tailTag,
	input  logic wbValid,
	input  logic [$clog2(ROB_DEPTH)-1:0] wbTag,
	input  logic [rnPkg::XLEN-1:0] wbData,
	input  logic outCredit,
	output logic retValid,
	output logic [rnPkg::REGW-1:0] retRd,
	output logic [rnPkg::XLEN-1:0] retData,
	output logic commitValid,
	output logic [rnPkg::REGW-1:0] commitReg,
	output logic [RB-1:0] commitNewCopy,
	output logic [RB-1:0] commitOldCopy
);
	import rnPkg::*;

	localparam int TW = $clog2(ROB_DEPTH);

	logic [REGW-1:0] entRd [ROB_DEPTH];
	logic [RB-1:0] entNew [ROB_DEPTH];
	logic [RB-1:0] entOld [ROB_DEPTH];
	logic [XLEN-1:0] entData [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] entDone;
	logic [TW-1:0] head;
	logic [TW:0] count;
	logic [OUT_CREDITS_MAX-1:0] credits;

	assign robFull = count == (TW+1)'(ROB_DEPTH);

	// head goes once it is done and the sink has room
	assign retValid = (count != '0) && entDone[head] && (credits != '0);
	assign retRd = entRd[head];
	assign retData = entData[head];

	assign commitValid = retValid;
	assign commitReg = entRd[head];
	assign commitNewCopy = entNew[head];
	assign commitOldCopy = entOld[head];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			head <= '0;
			tailTag <= '0;
			count <= '0;
			credits <= '0;
			entDone <= '0;
		end else begin
			if (robAlloc) begin
				tailTag <= tailTag + 1'b1;
				entDone[tailTag] <= 1'b0;
			end
			if (wbValid) begin
				entDone[wbTag] <= 1'b1;
			end
			if (retValid) begin
				head <= head + 1'b1;
			end
			count <= count + (TW+1)'(robAlloc) - (TW+1)'(retValid);
			credits <= credits + OUT_CREDITS_MAX'(outCredit) - OUT_CREDITS_MAX'(retValid);
		end
	end

	always_ff @(posedge CLK) begin
		if (robAlloc) begin
			entRd[tailTag] <= robRd;
			entNew[tailTag] <= robNewCopy;
			entOld[tailTag] <= robOldCopy;
		end
		if (wbValid) begin
			entData[wbTag] <= wbData;
		end
	end

	// sink never pushes the credit counter past its width
	creditWrap: assert property (@(posedge CLK) disable iff (!arstN)
		outCredit && !retValid |-> credits != '1);

	// execute only finishes entries still waiting
	wbLive: assert property (@(posedge CLK) disable iff (!arstN)
		wbValid |-> !entDone[wbTag] && count != '0);

endmodule

// ==== source/rnTop.sv ====
`timescale 1ns/10ps

module rnTop #(
	parameter int XLEN = rnPkg::XLEN,
	parameter int RP = rnPkg::RP,
	parameter int RB = rnPkg::RB,
	parameter int ROB_DEPTH = rnPkg::ROB_DEPTH
) (
	input  logic CLK,
	input  logic arstN,
	input  logic inValid,
	input  rnPkg::instrWord_u inInstr,
	output logic inCredit,
	input  logic outCredit,
	output logic retValid,
	output logic [rnPkg::REGW-1:0] retRd,
	output logic [XLEN-1:0] retData
);
	import rnPkg::*;

	// rename state
	logic [NREG-1:0][RB-1:0] renamePtr;
	logic [NREG-1:0][RP-1:0] inUse;
	logic [NREG-1:0][RP-1:0] writtenBack;
	logic renameValid;
	logic [REGW-1:0] renameReg;
	logic [RB-1:0] renameCopy;

	// rename to execute
	logic issueValid;
	logic issueReady;
	logic issueUseImm;
	logic [FUNC_W-1:0] issueOp;
	logic [REGW-1:0] issueRd, issueRs1, issueRs2;
	logic [RB-1:0] issueRdCopy, issueRs1Copy, issueRs2Copy;
	logic [XLEN-1:0] issueImm;
	logic [TAGW-1:0] issueTag;

	// reorder buffer allocation
	logic robAlloc;
	logic robFull;
	logic [REGW-1:0] robRd;
	logic [RB-1:0] robNewCopy, robOldCopy;
	logic [TAGW-1:0] tailTag;

	// operand reads and writeback
	logic [REGW-1:0] rdReg1, rdReg2;
	logic [RB-1:0] rdCopy1, rdCopy2;
	logic [XLEN-1:0] rdData1, rdData2;
	logic wbValid;
	logic [REGW-1:0] wbReg;
	logic [RB-1:0] wbCopy;
	logic [XLEN-1:0] wbData;
	logic [TAGW-1:0] wbTag;

	// retirement back into the register state
	logic commitValid;
	logic [REGW-1:0] commitReg;
	logic [RB-1:0] commitNewCopy, commitOldCopy;

	renameStage #(.RP(RP), .RB(RB), .XLEN(XLEN)) uRename (.*);

	execStage #(.XLEN(XLEN), .RB(RB)) uExec (.*);

	commitStage #(.RB(RB), .ROB_DEPTH(ROB_DEPTH)) uCommit (.*);

	phyRegister #(.XLEN(XLEN), .RP(RP), .RB(RB)) uPhyRegister (.*);

endmodule

// ==== dv/rnTb.sv ====
`timescale 1ns/10ps

module rnTb;
	import rnPkg::*;

	localparam int N_INIT = 31;
	localparam int N_RAND = 40;
	localparam int N_CHAIN = 24;
	localparam int N_BURST = 16;
	localparam int N_ZERO = 12;
	localparam int N_HOLD = 24;
	localparam int N_TOTAL = N_INIT + N_RAND + N_CHAIN + N_BURST + N_ZERO + N_HOLD;
	localparam int TIMEOUT_CYCLES = 40 * N_TOTAL + 200;
	// keeps the 4-bit credit counter in the DUT well clear of wrap
	localparam int SINK_MAX = 8;
	localparam int HOLD_CYCLES = 80;
	localparam int SINK_STEADY = 0;
	localparam int SINK_RANDOM = 1;
	localparam int KIND_ADD = 0;
	localparam int KIND_SUB = 1;
	localparam int KIND_XOR = 2;

	logic CLK = 1'b0;
	logic arstN;
	logic inValid;
	instrWord_u inInstr;
	logic inCredit;
	logic outCredit;
	logic retValid;
	logic [REGW-1:0] retRd;
	logic [XLEN-1:0] retData;

	logic [31:0] rngState;
	// x0 entry stays zero
	logic [XLEN-1:0] modelReg [NREG];
	instrWord_u pending [$];
	logic [REGW-1:0] expRd [$];
	logic [XLEN-1:0] expData [$];
	int senderCredits = INQ_DEPTH;
	int sinkCredits = 0;
	int creditPulses = 0;
	int retireCount = 0;
	int cycleCount = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	rnTop uut (.*);

	always #5 CLK = ~CLK;

	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	// RISC-V style R-form, SUB sets funct7 bit 5
	function automatic instrWord_u makeR(input int kind, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		instrWord_u w;
		w = '0;
		w.r.opcode = OP_R;
		w.r.rd = rd;
		w.r.rs1 = rs1;
		w.r.rs2 = rs2;
		w.r.funct3 = (kind == KIND_XOR) ? 3'b100 : 3'b000;
		w.r.funct7 = (kind == KIND_SUB) ? 7'b0100000 : 7'b0000000;
		return w;
	endfunction

	function automatic instrWord_u makeI(input int kind, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		instrWord_u w;
		w = '0;
		w.i.opcode = OP_I;
		w.i.rd = rd;
		w.i.rs1 = rs1;
		w.i.imm = imm;
		w.i.funct3 = (kind == KIND_XOR) ? 3'b100 : 3'b000;
		return w;
	endfunction

	function automatic instrWord_u randWord(input logic [4:0] rd, input logic [4:0] rs1);
		logic [31:0] r;
		r = nextRand();
		if (r[0]) begin
			return makeR(int'(r[2:1]) % 3, rd, rs1, r[7:3]);
		end
		return makeI(r[1] ? KIND_XOR : KIND_ADD, rd, rs1, r[19:8]);
	endfunction

	// expected result of one word on the model register file
	function automatic logic [XLEN-1:0] refExec(input instrWord_u w);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		a = (w.r.rs1 == 5'd0) ? '0 : modelReg[w.r.rs1];
		if (w.r.opcode == OP_R) begin
			b = (w.r.rs2 == 5'd0) ? '0 : modelReg[w.r.rs2];
			if (w.r.funct3 == 3'b100) begin
				return a ^ b;
			end
			return w.r.funct7[5] ? a - b : a + b;
		end
		b = {{(XLEN-12){w.i.imm[11]}}, w.i.imm};
		return (w.i.funct3 == 3'b100) ? a ^ b : a + b;
	endfunction

	task automatic predict(input instrWord_u w);
		logic [XLEN-1:0] v;
		v = refExec(w);
		expRd.push_back(w.r.rd);
		expData.push_back(v);
		if (w.r.rd != 5'd0) begin
			modelReg[w.r.rd] = v;
		end
	endtask

	task automatic checkRd(input logic [REGW-1:0] expected, input logic [REGW-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: retired rd x%0d, expected x%0d", $time, actual, expected);
		end
	endtask

	task automatic checkData(input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: retired data %h, expected %h", $time, actual, expected);
		end
	endtask

	// credit returns and retirements, sampled before the edge updates
	always @(posedge CLK) begin
		if (arstN) begin
			if (inCredit) begin
				creditPulses++;
				senderCredits++;
				if (senderCredits > INQ_DEPTH) begin
					errors++;
					$display("input credit returned with nothing outstanding at %0t", $time);
				end
			end
			if (retValid) begin
				retireCount++;
				if (sinkCredits == 0) begin
					errors++;
					$display("retirement without an output credit at %0t", $time);
				end else begin
					sinkCredits--;
				end
				if (expRd.size() == 0) begin
					errors++;
					$display("retirement with no instruction outstanding at %0t", $time);
				end else begin
					checkRd(expRd.pop_front(), retRd);
					checkData(expData.pop_front(), retData);
				end
			end
		end
	end

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount > TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// sends the pending words under input credits and drains them
	task automatic runTest(input string name, input int pattern, input int holdCycles);
		int errBefore;
		int pulsesBefore;
		int retBefore;
		int leftover;
		int sent;
		int cyc;
		logic [31:0] r;
		errBefore = errors;
		pulsesBefore = creditPulses;
		retBefore = retireCount;
		leftover = sinkCredits;
		sent = 0;
		cyc = 0;
		while (pending.size() > 0 || expRd.size() > 0) begin
			@(negedge CLK);
			inValid = 1'b0;
			outCredit = 1'b0;
			if (pending.size() > 0 && senderCredits > 0) begin
				inInstr = pending.pop_front();
				inValid = 1'b1;
				senderCredits--;
				sent++;
				predict(inInstr);
			end
			// end of the hold window, DUT must be stalled on both sides
			if (holdCycles > 0 && cyc == holdCycles) begin
				if (retireCount - retBefore > leftover) begin
					errors++;
					$display("%0d retired with only %0d output credits given",
						retireCount - retBefore, leftover);
				end
				if (senderCredits != 0 || pending.size() == 0) begin
					errors++;
					$display("input side did not stall while output credits were withheld");
				end
			end
			r = nextRand();
			if (cyc >= holdCycles && sinkCredits < SINK_MAX
					&& (pattern == SINK_STEADY || r[0])) begin
				outCredit = 1'b1;
				sinkCredits++;
			end
			cyc++;
		end
		@(negedge CLK);
		inValid = 1'b0;
		outCredit = 1'b0;
		if (creditPulses - pulsesBefore != sent || senderCredits != INQ_DEPTH) begin
			errors++;
			$display("input credits: %0d returned for %0d sent, sender holds %0d",
				creditPulses - pulsesBefore, sent, senderCredits);
		end
		tests++;
		$display("test %s finished: %0d instructions, %0d errors", name, sent,
			errors - errBefore);
	endtask

	initial begin
		logic [31:0] r;
		logic [4:0] prev;
		logic [4:0] rd;
		rngState = 32'h6ac4fa5a;
		arstN = 1'b0;
		inValid = 1'b0;
		inInstr = '0;
		outCredit = 1'b0;
		for (int i = 0; i < NREG; i++) begin
			modelReg[i] = '0;
		end
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		arstN = 1'b1;

		// give every register a known value first
		for (int i = 1; i < NREG; i++) begin
			r = nextRand();
			pending.push_back(makeI(KIND_ADD, REGW'(i), 5'd0, r[11:0]));
		end
		runTest("init", SINK_STEADY, 0);

		for (int k = 0; k < N_RAND; k++) begin
			r = nextRand();
			pending.push_back(randWord(r[4:0], r[9:5]));
		end
		runTest("random", SINK_RANDOM, 0);

		// each word reads the previous destination
		prev = 5'd1;
		for (int k = 0; k < N_CHAIN; k++) begin
			r = nextRand();
			rd = (r[4:0] == 5'd0) ? 5'd3 : r[4:0];
			pending.push_back(randWord(rd, prev));
			prev = rd;
		end
		runTest("chain", SINK_STEADY, 0);

		for (int k = 0; k < N_BURST; k++) begin
			r = nextRand();
			pending.push_back(randWord(5'd7, r[0] ? 5'd7 : r[5:1]));
		end
		runTest("burst", SINK_STEADY, 0);

		// writes to x0 alternate with reads of it
		for (int k = 0; k < N_ZERO; k++) begin
			r = nextRand();
			rd = (r[4:0] == 5'd0) ? 5'd9 : r[4:0];
			if (k % 2 == 0) begin
				pending.push_back(makeI(r[5] ? KIND_XOR : KIND_ADD, 5'd0, rd, r[27:16]));
			end else if (r[6]) begin
				pending.push_back(makeR(int'(r[8:7]) % 3, rd, 5'd0, r[13:9]));
			end else begin
				pending.push_back(makeI(KIND_ADD, rd, 5'd0, r[27:16]));
			end
		end
		runTest("zeroReg", SINK_STEADY, 0);

		for (int k = 0; k < N_HOLD; k++) begin
			r = nextRand();
			pending.push_back(randWord(r[4:0], r[9:5]));
		end
		runTest("creditHold", SINK_STEADY, HOLD_CYCLES);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
source/rnPkg.sv
source/phyRegister.sv
source/renameStage.sv
source/execStage.sv
source/commitStage.sv
source/rnTop.sv
dv/rnTb.sv

// ==== run.sh ====
#!/bin/sh
# build the rename core with its testbench and run it under Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rnTb \
	-f verilog.f -Mdir obj_dir -o rnSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/rnSim)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

printf '%s\n' "$simOut" | grep -qx "TEST RESULT: PASS" || exit 1
exit 0
